// File: Makefile
# Verilator build and run of the DAC mixer testbench

VERILATOR ?= verilator
TOP       ?= tb_dac_mix
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= PASS: all tests

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/dac_mix_checker.sv
/*
  Bus and DAC select properties of dac_mix_top, attached with bind.
  Sampled on adc_clk, all properties idle while rst_i is high.
  fail_cnt is read by the testbench at the end of the run.
*/
`timescale 1ns/1ns

module dac_mix_checker (
  input logic adc_clk,
  input logic rst_i,
  input logic dac_sel_i,
  input logic awready_i,
  input logic arready_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic rvalid_i,
  input logic rready_i
);

  int unsigned fail_cnt = 0;   // failed assertion count

  // --------------------
  // DAC bus
  a_sel_toggle: assert property (@(posedge adc_clk) disable iff (rst_i)
    1'b1 |=> dac_sel_i != $past(dac_sel_i))
    else begin
      fail_cnt++;
      $error("dac_sel_o held its value for two cycles");
    end

  // --------------------
  // AXI4-Lite responses
  a_b_hold: assert property (@(posedge adc_clk) disable iff (rst_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      fail_cnt++;
      $error("bvalid dropped before bready");
    end

  a_r_hold: assert property (@(posedge adc_clk) disable iff (rst_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else begin
      fail_cnt++;
      $error("rvalid dropped before rready");
    end

  a_one_resp: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(bvalid_i && rvalid_i))
    else begin
      fail_cnt++;
      $error("bvalid and rvalid high together");
    end

  // a pending response means the FSM has left IDLE
  a_addr_idle: assert property (@(posedge adc_clk) disable iff (rst_i)
    (awready_i || arready_i) |-> !bvalid_i && !rvalid_i)
    else begin
      fail_cnt++;
      $error("address accepted while a response is pending");
    end

endmodule

bind dac_mix_top dac_mix_checker u_checker (
  .adc_clk   (adc_clk),
  .rst_i     (rst_i),
  .dac_sel_i (dac_sel_o),
  .awready_i (s_awready_o),
  .arready_i (s_arready_o),
  .bvalid_i  (s_bvalid_o),
  .bready_i  (s_bready_i),
  .rvalid_i  (s_rvalid_o),
  .rready_i  (s_rready_i)
);

// File: bench/tb_dac_mix.sv
/*
  Testbench for dac_mix_top. Inputs change on the falling edge, and
  the DAC bus is compared with a model on every falling edge.
  Model constants assume 14-bit samples. One bus transaction at a time.
*/
`timescale 1ns/1ns
`include "dac_mix_params.svh"

module tb_dac_mix;

  localparam int clk_period = 100;
  localparam int n_rw       = 40;       // write and readback pairs
  localparam int n_bad      = 12;       // unmapped address probes
  localparam int n_stream   = 200;      // cycles per data path phase
  localparam int n_ops      = 64 + 2 * n_rw + 2 * n_bad + 3 * n_stream;
  localparam logic [1:0] resp_okay   = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;

  logic               adc_clk;
  logic               rst_i;
  logic [`MIX_DW-1:0] adc_dat_a_i;
  logic [`MIX_DW-1:0] adc_dat_b_i;
  logic               s_awvalid_i;
  logic               s_awready_o;
  logic [7:0]         s_awaddr_i;
  logic               s_wvalid_i;
  logic               s_wready_o;
  logic [31:0]        s_wdata_i;
  logic [3:0]         s_wstrb_i;
  logic               s_bvalid_o;
  logic               s_bready_i;
  logic [1:0]         s_bresp_o;
  logic               s_arvalid_i;
  logic               s_arready_o;
  logic [7:0]         s_araddr_i;
  logic               s_rvalid_o;
  logic               s_rready_i;
  logic [31:0]        s_rdata_o;
  logic [1:0]         s_rresp_o;
  logic [`MIX_DW-1:0] dac_dat_o;
  logic               dac_sel_o;

  logic [31:0] shadow [4];      // register image, index is addr/4
  int          res_new [2];     // model result of the last edge
  int          res_old [2];     // one edge earlier, now on the DAC bus
  int          n_edges;
  bit          adc_extreme;     // ADC codes from the corners only
  logic [7:0]  addr;
  int unsigned sat_pos_seen;
  int unsigned sat_neg_seen;
  int unsigned n_checks;
  int unsigned errors;
  int unsigned asrt;

  dac_mix_top i_dut (.*);

  initial begin
    adc_clk = 1'b0;
    forever #(clk_period / 2) adc_clk = ~adc_clk;
  end

  initial begin
    #(n_ops * 20 * clk_period);
    $display("timeout: the tests did not finish within %0d ns", n_ops * 20 * clk_period);
    $display("FAIL: see errors above");
    $finish;
  end

  // --------------------
  // checking and model
  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // ADC code to signed value, add offset, clamp to 14 bits
  function automatic int chan_model(input logic [`MIX_DW-1:0] code, input logic [31:0] ofs_reg,
                                    input logic en);
    int adc_v;
    int ofs_v;
    int sum;
    adc_v = 0;
    if (en) begin
      adc_v = int'(code ^ 14'h1FFF);    // negative slope, midscale at 0x1FFF/0x2000
      if (adc_v >= 8192) adc_v -= 16384;
    end
    ofs_v = int'(ofs_reg[13:0]);
    if (ofs_v >= 8192) ofs_v -= 16384;
    sum = adc_v + ofs_v;
    if (sum > 8191) sum = 8191;
    else if (sum < -8192) sum = -8192;
    return sum;
  endfunction

  function automatic logic [`MIX_DW-1:0] dac_code(input int v);
    logic [13:0] u;
    u = v[13:0];                        // two's complement bits
    return u ^ 14'h1FFF;
  endfunction

  function automatic logic [`MIX_DW-1:0] adc_code_pick(input bit extreme);
    logic [31:0] r;
    r = $urandom();
    if (!extreme) return r[`MIX_DW-1:0];
    case (r[1:0])
      2'd0:    return 14'h0000;         // most positive
      2'd1:    return 14'h3FFF;         // most negative
      2'd2:    return 14'h1FFF;         // zero
      default: return 14'h2000;         // minus one
    endcase
  endfunction

  // strobe merge into the writable registers only
  function automatic void shadow_write(input logic [7:0] a, input logic [31:0] d,
                                      input logic [3:0] strb);
    int          idx;
    logic [31:0] mask;
    if (!(a inside {`MIX_REG_OFS_A, `MIX_REG_OFS_B, `MIX_REG_CTRL})) return;
    idx  = a[3:2];
    mask = (a == `MIX_REG_CTRL) ? 32'h0003 : 32'h3FFF;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) shadow[idx][8*b +: 8] = d[8*b +: 8];
    end
    shadow[idx] = shadow[idx] & mask;
  endfunction

  always @(posedge adc_clk) begin
    n_edges++;
    res_old = res_new;
    if (rst_i) begin
      res_new = '{0, 0};
    end else begin
      res_new[0] = chan_model(adc_dat_a_i, shadow[0], shadow[2][0]);
      res_new[1] = chan_model(adc_dat_b_i, shadow[1], shadow[2][1]);
    end
    foreach (res_new[ch]) begin
      if (res_new[ch] == 8191) sat_pos_seen++;
      if (res_new[ch] == -8192) sat_neg_seen++;
    end
  end

  always @(negedge adc_clk) begin
    if (rst_i === 1'b0) begin            // new ADC sample every cycle
      adc_dat_a_i <= adc_code_pick(adc_extreme);
      adc_dat_b_i <= adc_code_pick(adc_extreme);
    end
    if (n_edges > 0) begin
      check_eq(32'(dac_dat_o), 32'(dac_code(res_old[dac_sel_o])), "dac_dat_o vs model");
    end
  end

  // --------------------
  // AXI4-Lite master
  task automatic axi_write(input logic [7:0] a, input logic [31:0] d, input logic [3:0] strb,
                           output logic [1:0] resp);
    @(negedge adc_clk);
    s_awvalid_i <= 1'b1;
    s_awaddr_i  <= a;
    s_wvalid_i  <= 1'b1;
    s_wdata_i   <= d;
    s_wstrb_i   <= strb;
    do @(posedge adc_clk); while (!s_awready_o && !s_wready_o);   // handshake edge
    check_eq(32'(s_wready_o), 32'(s_awready_o), "awready and wready together");
    @(negedge adc_clk);
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    shadow_write(a, d, strb);            // DUT took it on the last edge
    check_eq(32'(s_bvalid_o), 32'd1, "bvalid one cycle after the write handshake");
    while (!s_bvalid_o) @(negedge adc_clk);
    repeat ($urandom_range(4)) @(negedge adc_clk);
    resp = s_bresp_o;                    // value at the b handshake
    s_bready_i <= 1'b1;
    @(negedge adc_clk);
    s_bready_i <= 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] a, output logic [31:0] d, output logic [1:0] resp);
    @(negedge adc_clk);
    s_arvalid_i <= 1'b1;
    s_araddr_i  <= a;
    do @(posedge adc_clk); while (!s_arready_o);   // handshake edge
    @(negedge adc_clk);
    s_arvalid_i <= 1'b0;
    check_eq(32'(s_rvalid_o), 32'd1, "rvalid one cycle after the read handshake");
    while (!s_rvalid_o) @(negedge adc_clk);
    repeat ($urandom_range(4)) @(negedge adc_clk);
    d    = s_rdata_o;                    // values at the r handshake
    resp = s_rresp_o;
    s_rready_i <= 1'b1;
    @(negedge adc_clk);
    s_rready_i <= 1'b0;
  endtask

  task automatic write_check(input logic [7:0] a, input logic [31:0] d, input logic [3:0] strb);
    logic [1:0] resp;
    axi_write(a, d, strb, resp);
    if (a inside {`MIX_REG_OFS_A, `MIX_REG_OFS_B, `MIX_REG_CTRL}) begin
      check_eq(32'(resp), 32'(resp_okay), "bresp");
    end else begin
      check_eq(32'(resp), 32'(resp_slverr), "bresp");
    end
  endtask

  task automatic read_check(input logic [7:0] a);
    logic [31:0] d;
    logic [1:0]  resp;
    logic [31:0] exp_d;
    logic [1:0]  exp_r;
    exp_r = resp_okay;
    case (a)
      `MIX_REG_OFS_A, `MIX_REG_OFS_B, `MIX_REG_CTRL: exp_d = shadow[a[3:2]];
      `MIX_REG_ID: exp_d = `MIX_ID_VALUE;
      default: begin
        exp_d = '0;                       // holes read zero
        exp_r = resp_slverr;
      end
    endcase
    axi_read(a, d, resp);
    check_eq(d, exp_d, "rdata");
    check_eq(32'(resp), 32'(exp_r), "rresp");
  endtask

  // --------------------
  // test sequence
  initial begin
    void'($urandom(32'h78ef_ef7a));
    rst_i       = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    s_awvalid_i = 1'b0;
    s_awaddr_i  = '0;
    s_wvalid_i  = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_bready_i  = 1'b0;
    s_arvalid_i = 1'b0;
    s_araddr_i  = '0;
    s_rready_i  = 1'b0;
    adc_extreme = 1'b0;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_i <= 1'b0;

    check_eq(32'(dac_dat_o), 32'(dac_code(0)), "dac_dat_o after reset");
    for (int a = 0; a < 16; a += 4) read_check(8'(a));

    repeat (n_rw) begin                  // strobe merge and readback
      addr = 8'(4 * $urandom_range(2));
      write_check(addr, $urandom(), 4'($urandom_range(15)));
      read_check(addr);
    end
    repeat (n_bad) begin
      do addr = 8'($urandom()); while (addr inside {8'h00, 8'h04, 8'h08, 8'h0C});
      write_check(addr, $urandom(), 4'hF);
      read_check(addr);
    end
    write_check(`MIX_REG_ID, $urandom(), 4'hF);
    read_check(`MIX_REG_ID);

    write_check(`MIX_REG_OFS_A, $urandom(), 4'hF);   // random offsets, both adding
    write_check(`MIX_REG_OFS_B, $urandom(), 4'hF);
    write_check(`MIX_REG_CTRL, 32'h3, 4'hF);
    repeat (n_stream) @(negedge adc_clk);

    write_check(`MIX_REG_OFS_A, 32'h1FFF, 4'hF);     // push both clamps
    write_check(`MIX_REG_OFS_B, 32'h2000, 4'hF);
    adc_extreme  = 1'b1;
    sat_pos_seen = 0;
    sat_neg_seen = 0;
    repeat (n_stream) @(negedge adc_clk);
    check_eq(32'(sat_pos_seen != 0), 32'd1, "positive clamp reached");
    check_eq(32'(sat_neg_seen != 0), 32'd1, "negative clamp reached");
    adc_extreme = 1'b0;

    for (int ch = 0; ch < 2; ch++) begin   // disabled channel carries its offset
      write_check(`MIX_REG_CTRL, 32'(2 - ch), 4'h1);
      write_check(8'(4 * ch), $urandom(), 4'h3);
      repeat (4) @(negedge adc_clk);
      repeat (n_stream / 2) begin
        @(negedge adc_clk);
        if (dac_sel_o == ch[0]) begin
          check_eq(32'(dac_dat_o), 32'(dac_code(chan_model('0, shadow[ch], 1'b0))),
                   "offset only on disabled channel");
        end
      end
    end

    repeat (10) begin                     // reads under b/r stalls
      read_check(`MIX_REG_CTRL);
      read_check(`MIX_REG_ID);
    end

    asrt = i_dut.u_checker.fail_cnt;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", n_checks, errors, asrt);
    if (errors == 0 && asrt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: hw/chan_sum_sat.sv
/*
  One channel stage: ADC code to two's complement, plus offset,
  clamped to MIX_DW bits. One register stage, no back-pressure.
  With the enable low only the offset reaches the output.
*/
`timescale 1ns/1ns
`include "dac_mix_params.svh"

module chan_sum_sat
  import mix_signal_pkg::*;
(
  input  logic              adc_clk,
  input  logic              rst_i,
  input  logic [`MIX_DW-1:0] adc_code_i,   // raw neg-slope offset binary
  input  sample_t           ofs_i,
  input  logic              add_en_i,
  output sample_t           res_o
);

  localparam sample_t sat_pos = {1'b0, {(`MIX_DW-1){1'b1}}};   // 0x1FFF
  localparam sample_t sat_neg = {1'b1, {(`MIX_DW-1){1'b0}}};   // 0x2000

  sample_t adc_s;
  sum_t    sum;
  sample_t sat;

  assign adc_s = add_en_i ? sample_t'(offset_bin_flip(adc_code_i)) : '0;
  assign sum   = sum_t'(adc_s) + sum_t'(ofs_i);   // sign extended, cannot wrap

  // top two bits differ only on overflow
  always_comb begin
    case (sum[`MIX_DW:`MIX_DW-1])
      2'b01:   sat = sat_pos;                // pos. overflow
      2'b10:   sat = sat_neg;                // neg. overflow
      default: sat = sum[`MIX_DW-1:0];
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      res_o <= '0;
    end else begin
      res_o <= sat;
    end
  end

endmodule

// File: hw/dac_interleave.sv
/*
  Time-multiplexes both channel results onto the combined DAC bus.
  dac_sel_o toggles every cycle, 0 marks channel A, and dac_dat_o
  always carries the channel named by dac_sel_o in DAC coding.
*/
`timescale 1ns/1ns
`include "dac_mix_params.svh"

module dac_interleave
  import mix_signal_pkg::*;
(
  input  logic               adc_clk,
  input  logic               rst_i,
  input  sample_t            res_a_i,
  input  sample_t            res_b_i,
  output logic [`MIX_DW-1:0] dac_dat_o,
  output logic               dac_sel_o
);

  logic    phase_q;                            // channel on the bus now
  logic    phase_d;
  sample_t pick;

  assign phase_d = ~phase_q;
  assign pick    = phase_d ? res_b_i : res_a_i;   // load the channel of the next phase

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      phase_q   <= 1'b0;
      dac_dat_o <= offset_bin_flip('0);         // recoded zero
    end else begin
      phase_q   <= phase_d;
      dac_dat_o <= offset_bin_flip(pick);       // back to DAC coding
    end
  end

  assign dac_sel_o = phase_q;

endmodule

// File: hw/dac_mix_params.svh
/*
  Widths, channel count and register map of the DAC mixer.
  Register offsets are byte addresses on the AXI4-Lite bus. Only
  word-aligned offsets are decoded, and everything else is unmapped.
*/
`ifndef DAC_MIX_PARAMS_SVH
`define DAC_MIX_PARAMS_SVH

// --------------------
// data path
`define MIX_DW         14            // ADC and DAC sample width
`define MIX_NCH        2             // channel count, A and B

// --------------------
// bus and register map
`define MIX_AW         8             // AXI byte address width

`define MIX_REG_OFS_A  8'h00         // channel A offset, signed
`define MIX_REG_OFS_B  8'h04         // channel B offset, signed
`define MIX_REG_CTRL   8'h08         // [1:0] ADC add enables
`define MIX_REG_ID     8'h0C         // read only

`define MIX_ID_VALUE   32'h4d49_5831 // "MIX1"

`endif

// File: hw/dac_mix_top.sv
/*
  DAC mixer top: register block, one stage per channel, interleaver.
  Single clock domain on adc_clk, synchronous reset rst_i.
  ADC inputs are expected already registered at the pins.
*/
`timescale 1ns/1ns
`include "dac_mix_params.svh"

module dac_mix_top
  import mix_bus_pkg::*;
  import mix_signal_pkg::*;
(
  input  logic               adc_clk,
  input  logic               rst_i,
  input  logic [`MIX_DW-1:0] adc_dat_a_i,   // ADC CH1
  input  logic [`MIX_DW-1:0] adc_dat_b_i,   // ADC CH2
  // AXI4-Lite slave
  input  logic               s_awvalid_i,
  output logic               s_awready_o,
  input  axi_addr_t          s_awaddr_i,
  input  logic               s_wvalid_i,
  output logic               s_wready_o,
  input  axi_data_t          s_wdata_i,
  input  axi_strb_t          s_wstrb_i,
  output logic               s_bvalid_o,
  input  logic               s_bready_i,
  output axi_resp_e          s_bresp_o,
  input  logic               s_arvalid_i,
  output logic               s_arready_o,
  input  axi_addr_t          s_araddr_i,
  output logic               s_rvalid_o,
  input  logic               s_rready_i,
  output axi_data_t          s_rdata_o,
  output axi_resp_e          s_rresp_o,
  // DAC
  output logic [`MIX_DW-1:0] dac_dat_o,     // combined data
  output logic               dac_sel_o      // channel select
);

  logic [`MIX_NCH-1:0][`MIX_DW-1:0] adc_dat;   // index 0 is channel A
  sample_t [`MIX_NCH-1:0]           ofs;
  logic [`MIX_NCH-1:0]              add_en;
  sample_t [`MIX_NCH-1:0]           res;

  assign adc_dat = {adc_dat_b_i, adc_dat_a_i};

  // --------------------
  // registers
  mix_regs u_regs (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_awaddr_i  (s_awaddr_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_bresp_o   (s_bresp_o),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_araddr_i  (s_araddr_i),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .ofs_o       (ofs),
    .add_en_o    (add_en)
  );

  // --------------------
  // channel stages
  for (genvar gi = 0; gi < `MIX_NCH; gi++) begin : g_chan
    chan_sum_sat u_chan (
      .adc_clk    (adc_clk),
      .rst_i      (rst_i),
      .adc_code_i (adc_dat[gi]),
      .ofs_i      (ofs[gi]),
      .add_en_i   (add_en[gi]),
      .res_o      (res[gi])
    );
  end

  // --------------------
  // DAC bus
  dac_interleave u_dac (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .res_a_i   (res[0]),
    .res_b_i   (res[1]),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

endmodule

// File: hw/mix_bus_pkg.sv
/*
  AXI4-Lite types shared by the register block and the top level.
  The data bus is fixed at 32 bits with four byte strobes.
*/
`include "dac_mix_params.svh"

package mix_bus_pkg;

  typedef logic [`MIX_AW-1:0] axi_addr_t;  // byte address
  typedef logic [31:0]        axi_data_t;
  typedef logic [3:0]         axi_strb_t;  // one bit per byte lane

  // response codes, EXOKAY and DECERR never issued
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } axi_resp_e;

  // slave FSM, one transaction at a time
  typedef enum logic [1:0] {
    IDLE,
    WRESP,
    RDATA
  } bus_state_e;

endpackage

// File: hw/mix_regs.sv
/*
  AXI4-Lite slave with the offset and control registers.
  One outstanding transaction, writes win over reads in IDLE.
  Offsets keep only MIX_DW bits and read back zero extended.
  Unmapped addresses and ID writes answer SLVERR.
*/
`timescale 1ns/1ns
`include "dac_mix_params.svh"

module mix_regs
  import mix_bus_pkg::*;
  import mix_signal_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   rst_i,
  // AXI4-Lite slave
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  input  axi_addr_t              s_awaddr_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  input  axi_data_t              s_wdata_i,
  input  axi_strb_t              s_wstrb_i,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  output axi_resp_e              s_bresp_o,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  input  axi_addr_t              s_araddr_i,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i,
  output axi_data_t              s_rdata_o,
  output axi_resp_e              s_rresp_o,
  // to the channel stages
  output sample_t [`MIX_NCH-1:0] ofs_o,
  output logic [`MIX_NCH-1:0]    add_en_o
);

  bus_state_e             state_q;
  sample_t [`MIX_NCH-1:0] ofs_q;       // per-channel offset
  logic [`MIX_NCH-1:0]    en_q;        // per-channel ADC add enable
  logic [`MIX_NCH-1:0]    ofs_hit;     // write address selects an offset
  logic                   wr_hs;
  logic                   rd_hs;
  axi_resp_e              wr_resp;
  axi_resp_e              rd_resp;
  axi_data_t              rd_data;
  axi_resp_e              bresp_q;
  axi_resp_e              rresp_q;
  axi_data_t              rdata_q;

  // --------------------
  // handshakes
  assign wr_hs = (state_q == IDLE) && s_awvalid_i && s_wvalid_i;   // aw and w together
  assign rd_hs = (state_q == IDLE) && s_arvalid_i && !s_awvalid_i && !s_wvalid_i;

  assign s_awready_o = wr_hs;
  assign s_wready_o  = wr_hs;
  assign s_arready_o = rd_hs;
  assign s_bvalid_o  = (state_q == WRESP);   // held until bready
  assign s_rvalid_o  = (state_q == RDATA);   // held until rready
  assign s_bresp_o   = bresp_q;
  assign s_rresp_o   = rresp_q;
  assign s_rdata_o   = rdata_q;

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (wr_hs) state_q <= WRESP;
                 else if (rd_hs) state_q <= RDATA;
        WRESP:   if (s_bready_i) state_q <= IDLE;
        RDATA:   if (s_rready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // --------------------
  // write side
  assign ofs_hit = {s_awaddr_i == `MIX_REG_OFS_B, s_awaddr_i == `MIX_REG_OFS_A};

  always_comb begin
    case (s_awaddr_i)
      `MIX_REG_OFS_A, `MIX_REG_OFS_B, `MIX_REG_CTRL: wr_resp = OKAY;
      default: wr_resp = SLVERR;              // ID register and holes
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      ofs_q <= '0;
      en_q  <= '0;
    end else if (wr_hs) begin
      for (int ch = 0; ch < `MIX_NCH; ch++) begin
        if (ofs_hit[ch] && s_wstrb_i[0]) ofs_q[ch][7:0] <= s_wdata_i[7:0];
        if (ofs_hit[ch] && s_wstrb_i[1]) ofs_q[ch][`MIX_DW-1:8] <= s_wdata_i[`MIX_DW-1:8];
      end
      if (s_awaddr_i == `MIX_REG_CTRL && s_wstrb_i[0]) begin
        en_q <= s_wdata_i[`MIX_NCH-1:0];
      end
    end
  end

  // --------------------
  // read side
  always_comb begin
    rd_data = '0;                             // holes read as zero
    rd_resp = OKAY;
    case (s_araddr_i)
      `MIX_REG_OFS_A: rd_data = {{(32-`MIX_DW){1'b0}}, ofs_q[0]};
      `MIX_REG_OFS_B: rd_data = {{(32-`MIX_DW){1'b0}}, ofs_q[1]};
      `MIX_REG_CTRL:  rd_data = {{(32-`MIX_NCH){1'b0}}, en_q};
      `MIX_REG_ID:    rd_data = `MIX_ID_VALUE;
      default:        rd_resp = SLVERR;
    endcase
  end

  // response payload, captured at the handshake
  always_ff @(posedge adc_clk) begin
    if (wr_hs) bresp_q <= wr_resp;
    if (rd_hs) begin
      rresp_q <= rd_resp;
      rdata_q <= rd_data;
    end
  end

  assign ofs_o    = ofs_q;
  assign add_en_o = en_q;

endmodule

// File: hw/mix_signal_pkg.sv
/*
  Sample types and the converter coding rule.
  ADC and DAC both use negative-slope offset binary, so one flip
  rule converts in either direction.
*/
`include "dac_mix_params.svh"

package mix_signal_pkg;

  typedef logic signed [`MIX_DW-1:0] sample_t;  // two's complement sample
  typedef logic signed [`MIX_DW:0]   sum_t;     // one guard bit for the add

  // keep msb, invert the rest
  function automatic logic [`MIX_DW-1:0] offset_bin_flip(input logic [`MIX_DW-1:0] code);
    return {code[`MIX_DW-1], ~code[`MIX_DW-2:0]};
  endfunction

endpackage

// File: verilog.f
+incdir+hw
hw/mix_bus_pkg.sv
hw/mix_signal_pkg.sv
hw/mix_regs.sv
hw/chan_sum_sat.sv
hw/dac_interleave.sv
hw/dac_mix_top.sv
bench/dac_mix_checker.sv
bench/tb_dac_mix.sv
